/* logic/fwd_defines.svh */
`ifndef FWD_DEFINES_SVH
`define FWD_DEFINES_SVH

// datapath width of the RV32 integer core
`define XLEN 32

// major opcodes seen by the forwarding path
`define OPCODE_LOAD        7'b0000011
`define OPCODE_ENVIRONMENT 7'b1110011  // csrrw and friends
`define OPCODE_LUI         7'b0110111
`define OPCODE_JAL         7'b1101111
`define OPCODE_JALR        7'b1100111
`define OPCODE_OP          7'b0110011
`define OPCODE_OP_IMM      7'b0010011

// load size codes, funct3 field of a LOAD
`define FUNCT3_LB  3'b000
`define FUNCT3_LH  3'b001
`define FUNCT3_LW  3'b010
`define FUNCT3_LBU 3'b100
`define FUNCT3_LHU 3'b101

`endif

/* logic/fwd_pkg.sv */
`default_nettype none

`include "fwd_defines.svh"

package fwd_pkg;

    // result of the instruction leaving EX
    typedef struct packed {
        logic [6:0]        opcode;
        logic [4:0]        rd;
        logic              reg_write;
        logic [2:0]        funct3;          // load size
        logic [`XLEN-1:0]  imm;             // for LUI
        logic [`XLEN-1:0]  alu_result;      // also the load address
        logic [`XLEN-1:0]  csr_read_data;
        logic [`XLEN-1:0]  pc_plus_4;       // link value of JAL and JALR
        logic              csr_write;
        logic [11:0]       csr_addr;
        logic [`XLEN-1:0]  csr_write_data;
    } ex_result_t;

    // same descriptor once the load data has been aligned in MEM
    typedef struct packed {
        logic [6:0]        opcode;
        logic [4:0]        rd;
        logic              reg_write;
        logic [2:0]        funct3;
        logic [`XLEN-1:0]  imm;
        logic [`XLEN-1:0]  alu_result;
        logic [`XLEN-1:0]  csr_read_data;
        logic [`XLEN-1:0]  pc_plus_4;
        logic              csr_write;
        logic [11:0]       csr_addr;
        logic [`XLEN-1:0]  csr_write_data;
        logic [`XLEN-1:0]  load_data;       // extended load value
    } mem_result_t;

    // sources of the instruction entering EX
    typedef struct packed {
        logic [4:0]        rs1;
        logic [4:0]        rs2;
        logic [11:0]       csr_addr;
        logic [`XLEN-1:0]  csr_read_data;   // value read from the CSR file
    } src_req_t;

    typedef enum logic [1:0] {
        SEL_NONE = 2'b00,
        SEL_MEM  = 2'b10,
        SEL_WB   = 2'b11
    } fwd_sel_t;

    // hits of one stage, rs1_hit is bit 0
    typedef struct packed {
        logic csr_hit;
        logic rs2_hit;
        logic rs1_hit;
    } hazard_t;

endpackage

`default_nettype wire

/* logic/stage_reg.sv */
`timescale 1ns/10ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  wire      clk,
    input  wire      reset,
    input  wire      in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // valid bit is the only control state of the stage
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // payload is captured every cycle, a bubble just carries stale data
    always_ff @(posedge clk) begin
        out_data <= in_data;
    end

endmodule

`default_nettype wire

/* logic/load_align.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fwd_defines.svh"

module load_align (
    input  wire  [`XLEN-1:0] raw_data,   // whole memory word
    input  wire  [1:0]       addr_low,
    input  wire  [2:0]       funct3,
    output logic [`XLEN-1:0] load_data
);

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    // byte lane picked by the two low address bits
    always_comb begin
        case (addr_low)
            2'd0:    sel_byte = raw_data[7:0];
            2'd1:    sel_byte = raw_data[15:8];
            2'd2:    sel_byte = raw_data[23:16];
            default: sel_byte = raw_data[31:24];
        endcase
    end

    // halfword lane, bit 0 is ignored for halves
    always_comb begin
        if (addr_low[1]) begin
            sel_half = raw_data[31:16];
        end else begin
            sel_half = raw_data[15:0];
        end
    end

    always_comb begin
        case (funct3)
            `FUNCT3_LB: begin
                load_data = {{(`XLEN-8){sel_byte[7]}}, sel_byte};   // sign extend
            end
            `FUNCT3_LH: begin
                load_data = {{(`XLEN-16){sel_half[15]}}, sel_half};
            end
            `FUNCT3_LBU: begin
                load_data = {{(`XLEN-8){1'b0}}, sel_byte};          // zero extend
            end
            `FUNCT3_LHU: begin
                load_data = {{(`XLEN-16){1'b0}}, sel_half};
            end
            default: begin
                load_data = raw_data;   // LW and anything else
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/hazard_detect.sv */
`timescale 1ns/10ps
`default_nettype none

module hazard_detect (
    input  wire fwd_pkg::src_req_t    src,
    input  wire                       mem_valid,
    input  wire fwd_pkg::ex_result_t  mem_stage,
    input  wire                       wb_valid,
    input  wire fwd_pkg::mem_result_t wb_stage,
    output fwd_pkg::hazard_t          hazard_mem,
    output fwd_pkg::hazard_t          hazard_wb
);

    // a producer counts only when it really writes a nonzero rd
    function automatic logic reg_match(
        input logic       valid,
        input logic       reg_write,
        input logic [4:0] rd,
        input logic [4:0] rs
    );
        return valid && reg_write && (rd != 5'd0) && (rd == rs);
    endfunction

    function automatic logic csr_match(
        input logic        valid,
        input logic        csr_write,
        input logic [11:0] dst_addr,
        input logic [11:0] src_addr
    );
        return valid && csr_write && (dst_addr == src_addr);
    endfunction

    always_comb begin
        hazard_mem.rs1_hit = reg_match(mem_valid, mem_stage.reg_write, mem_stage.rd, src.rs1);
        hazard_mem.rs2_hit = reg_match(mem_valid, mem_stage.reg_write, mem_stage.rd, src.rs2);
        hazard_mem.csr_hit = csr_match(mem_valid, mem_stage.csr_write, mem_stage.csr_addr,
                                       src.csr_addr);
    end

    // same rule one stage further down
    always_comb begin
        hazard_wb.rs1_hit = reg_match(wb_valid, wb_stage.reg_write, wb_stage.rd, src.rs1);
        hazard_wb.rs2_hit = reg_match(wb_valid, wb_stage.reg_write, wb_stage.rd, src.rs2);
        hazard_wb.csr_hit = csr_match(wb_valid, wb_stage.csr_write, wb_stage.csr_addr,
                                      src.csr_addr);
    end

endmodule

`default_nettype wire

/* logic/forward_unit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fwd_defines.svh"

module forward_unit (
    input  wire fwd_pkg::hazard_t     hazard_mem,
    input  wire fwd_pkg::hazard_t     hazard_wb,
    input  wire fwd_pkg::ex_result_t  mem_stage,
    input  wire [`XLEN-1:0]           mem_load_data,   // aligned in this cycle
    input  wire fwd_pkg::mem_result_t wb_stage,
    input  wire [`XLEN-1:0]           csr_read_data,   // from the CSR file
    output logic [`XLEN-1:0]          alu_forward_data_a,
    output logic [`XLEN-1:0]          alu_forward_data_b,
    output fwd_pkg::fwd_sel_t         alu_forward_select_a,
    output fwd_pkg::fwd_sel_t         alu_forward_select_b,
    output logic [`XLEN-1:0]          csr_forward_data
);

    import fwd_pkg::*;

    logic [`XLEN-1:0] mem_fwd_value;
    logic [`XLEN-1:0] wb_fwd_value;

    // value a stage would write back to rd
    function automatic logic [`XLEN-1:0] stage_value(
        input logic [6:0]       opcode,
        input logic [`XLEN-1:0] load_data,
        input logic [`XLEN-1:0] csr_data,
        input logic [`XLEN-1:0] imm,
        input logic [`XLEN-1:0] pc_plus_4,
        input logic [`XLEN-1:0] alu_result
    );
        logic [`XLEN-1:0] value;
        case (opcode)
            `OPCODE_LOAD:        value = load_data;
            `OPCODE_ENVIRONMENT: value = csr_data;    // old CSR value goes to rd
            `OPCODE_LUI:         value = imm;
            `OPCODE_JAL:         value = pc_plus_4;
            `OPCODE_JALR:        value = pc_plus_4;
            default:             value = alu_result;
        endcase
        return value;
    endfunction

    assign mem_fwd_value = stage_value(mem_stage.opcode, mem_load_data,
                                       mem_stage.csr_read_data, mem_stage.imm,
                                       mem_stage.pc_plus_4, mem_stage.alu_result);

    assign wb_fwd_value = stage_value(wb_stage.opcode, wb_stage.load_data,
                                      wb_stage.csr_read_data, wb_stage.imm,
                                      wb_stage.pc_plus_4, wb_stage.alu_result);

    // younger producer in MEM wins over WB
    assign alu_forward_select_a = hazard_mem.rs1_hit ? SEL_MEM :
                                  hazard_wb.rs1_hit  ? SEL_WB  : SEL_NONE;
    assign alu_forward_select_b = hazard_mem.rs2_hit ? SEL_MEM :
                                  hazard_wb.rs2_hit  ? SEL_WB  : SEL_NONE;

    assign alu_forward_data_a = hazard_mem.rs1_hit ? mem_fwd_value :
                                hazard_wb.rs1_hit  ? wb_fwd_value  : {`XLEN{1'b0}};
    assign alu_forward_data_b = hazard_mem.rs2_hit ? mem_fwd_value :
                                hazard_wb.rs2_hit  ? wb_fwd_value  : {`XLEN{1'b0}};

    // pending CSR writes shadow the file value
    always_comb begin
        if (hazard_mem.csr_hit) begin
            csr_forward_data = mem_stage.csr_write_data;
        end else if (hazard_wb.csr_hit) begin
            csr_forward_data = wb_stage.csr_write_data;
        end else begin
            csr_forward_data = csr_read_data;
        end
    end

endmodule

`default_nettype wire

/* logic/forward_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fwd_defines.svh"

module forward_top (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      ex_valid,
    input  wire fwd_pkg::ex_result_t ex_result,
    input  wire [`XLEN-1:0]          mem_read_data,   // raw word of the load in MEM
    input  wire fwd_pkg::src_req_t   src,
    output logic [`XLEN-1:0]         alu_forward_data_a,
    output logic [`XLEN-1:0]         alu_forward_data_b,
    output fwd_pkg::fwd_sel_t        alu_forward_select_a,
    output fwd_pkg::fwd_sel_t        alu_forward_select_b,
    output logic [`XLEN-1:0]         csr_forward_data
);

    import fwd_pkg::*;

    logic             mem_valid;
    ex_result_t       mem_stage;
    logic [`XLEN-1:0] aligned_load;
    mem_result_t      mem_result;
    logic             wb_valid;
    mem_result_t      wb_stage;
    hazard_t          hazard_mem;
    hazard_t          hazard_wb;

    stage_reg #(.payload_t(ex_result_t)) i_ex_mem (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (ex_valid),
        .in_data   (ex_result),
        .out_valid (mem_valid),
        .out_data  (mem_stage)
    );

    load_align i_load_align (
        .raw_data  (mem_read_data),
        .addr_low  (mem_stage.alu_result[1:0]),
        .funct3    (mem_stage.funct3),
        .load_data (aligned_load)
    );

    // MEM descriptor plus the aligned load value
    assign mem_result = '{
        opcode:         mem_stage.opcode,
        rd:             mem_stage.rd,
        reg_write:      mem_stage.reg_write,
        funct3:         mem_stage.funct3,
        imm:            mem_stage.imm,
        alu_result:     mem_stage.alu_result,
        csr_read_data:  mem_stage.csr_read_data,
        pc_plus_4:      mem_stage.pc_plus_4,
        csr_write:      mem_stage.csr_write,
        csr_addr:       mem_stage.csr_addr,
        csr_write_data: mem_stage.csr_write_data,
        load_data:      aligned_load
    };

    stage_reg #(.payload_t(mem_result_t)) i_mem_wb (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (mem_valid),
        .in_data   (mem_result),
        .out_valid (wb_valid),
        .out_data  (wb_stage)
    );

    hazard_detect i_hazard_detect (
        .src        (src),
        .mem_valid  (mem_valid),
        .mem_stage  (mem_stage),
        .wb_valid   (wb_valid),
        .wb_stage   (wb_stage),
        .hazard_mem (hazard_mem),
        .hazard_wb  (hazard_wb)
    );

    forward_unit i_forward_unit (
        .hazard_mem           (hazard_mem),
        .hazard_wb            (hazard_wb),
        .mem_stage            (mem_stage),
        .mem_load_data        (aligned_load),
        .wb_stage             (wb_stage),
        .csr_read_data        (src.csr_read_data),
        .alu_forward_data_a   (alu_forward_data_a),
        .alu_forward_data_b   (alu_forward_data_b),
        .alu_forward_select_a (alu_forward_select_a),
        .alu_forward_select_b (alu_forward_select_b),
        .csr_forward_data     (csr_forward_data)
    );

endmodule

`default_nettype wire

/* tb/forward_checker.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fwd_defines.svh"

module forward_checker (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      active,
    input  wire                      finish_req,
    input  wire [7:0]                test_id,
    input  wire                      ex_valid,
    input  wire fwd_pkg::ex_result_t ex_result,
    input  wire [`XLEN-1:0]          mem_read_data,
    input  wire fwd_pkg::src_req_t   src,
    input  wire [`XLEN-1:0]          alu_forward_data_a,
    input  wire [`XLEN-1:0]          alu_forward_data_b,
    input  wire fwd_pkg::fwd_sel_t   alu_forward_select_a,
    input  wire fwd_pkg::fwd_sel_t   alu_forward_select_b,
    input  wire [`XLEN-1:0]          csr_forward_data,
    output logic                     done,
    output int                       error_count
);

    import fwd_pkg::*;

    logic        m_valid;
    logic        w_valid;
    ex_result_t  m_desc;
    ex_result_t  w_desc;
    logic [31:0] w_load;     // extended load value held in WB
    logic [7:0]  cur_test;
    logic        seen_test;
    int          test_errors;
    int          tests_run;
    int          tests_failed;

    function automatic logic [31:0] extend_load(input logic [31:0] word,
                                                input logic [1:0] off,
                                                input logic [2:0] f3);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(word >> (8 * off));
        h = off[1] ? word[31:16] : word[15:0];
        case (f3)
            `FUNCT3_LB:  return {{24{b[7]}}, b};
            `FUNCT3_LH:  return {{16{h[15]}}, h};
            `FUNCT3_LBU: return {24'd0, b};
            `FUNCT3_LHU: return {16'd0, h};
            default:     return word;
        endcase
    endfunction

    // what the stage would hand to a dependent instruction
    function automatic logic [31:0] stage_result(input ex_result_t d, input logic [31:0] ld);
        case (d.opcode)
            `OPCODE_LOAD:                return ld;
            `OPCODE_ENVIRONMENT:         return d.csr_read_data;
            `OPCODE_LUI:                 return d.imm;
            `OPCODE_JAL, `OPCODE_JALR:   return d.pc_plus_4;
            default:                     return d.alu_result;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic close_test();
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %0d: %s, %0d mismatches", cur_test,
                 (test_errors == 0) ? "ok" : "bad", test_errors);
    endtask

    task automatic compare_outputs();
        logic        mh1, mh2, mhc, wh1, wh2, whc;
        logic [31:0] mv, wv, exp_a, exp_b, exp_c;
        logic [1:0]  sa, sb;
        mh1 = m_valid && m_desc.reg_write && m_desc.rd != 0 && m_desc.rd == src.rs1;
        mh2 = m_valid && m_desc.reg_write && m_desc.rd != 0 && m_desc.rd == src.rs2;
        wh1 = w_valid && w_desc.reg_write && w_desc.rd != 0 && w_desc.rd == src.rs1;
        wh2 = w_valid && w_desc.reg_write && w_desc.rd != 0 && w_desc.rd == src.rs2;
        mhc = m_valid && m_desc.csr_write && m_desc.csr_addr == src.csr_addr;
        whc = w_valid && w_desc.csr_write && w_desc.csr_addr == src.csr_addr;
        mv = stage_result(m_desc, extend_load(mem_read_data, m_desc.alu_result[1:0],
                                              m_desc.funct3));
        wv = stage_result(w_desc, w_load);
        sa    = mh1 ? 2'b10 : (wh1 ? 2'b11 : 2'b00);
        sb    = mh2 ? 2'b10 : (wh2 ? 2'b11 : 2'b00);
        exp_a = mh1 ? mv : (wh1 ? wv : 32'd0);
        exp_b = mh2 ? mv : (wh2 ? wv : 32'd0);
        exp_c = mhc ? m_desc.csr_write_data : (whc ? w_desc.csr_write_data : src.csr_read_data);
        check_value("alu_forward_select_a", {30'd0, alu_forward_select_a}, {30'd0, sa});
        check_value("alu_forward_select_b", {30'd0, alu_forward_select_b}, {30'd0, sb});
        check_value("alu_forward_data_a", alu_forward_data_a, exp_a);
        check_value("alu_forward_data_b", alu_forward_data_b, exp_b);
        check_value("csr_forward_data", csr_forward_data, exp_c);
    endtask

    initial begin
        done         = 1'b0;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        seen_test    = 1'b0;
        test_errors  = 0;
        cur_test     = 8'd0;
        m_valid      = 1'b0;
        w_valid      = 1'b0;
        m_desc       = '0;
        w_desc       = '0;
        w_load       = '0;
    end

    always @(posedge clk) begin
        if (reset) begin
            m_valid = 1'b0;
            w_valid = 1'b0;
        end else begin
            w_valid = m_valid;   // MEM moves to WB with its aligned load
            w_desc  = m_desc;
            w_load  = extend_load(mem_read_data, m_desc.alu_result[1:0], m_desc.funct3);
            m_valid = ex_valid;
            m_desc  = ex_result;
        end
        #90;   // just before the next edge
        if (active) begin
            if (seen_test && test_id != cur_test) begin
                close_test();
            end
            if (!seen_test || test_id != cur_test) begin
                cur_test    = test_id;
                test_errors = 0;
                seen_test   = 1'b1;
            end
            compare_outputs();
        end
    end

    always @(posedge finish_req) begin
        if (seen_test) begin
            close_test();
        end
        $display("summary: %0d tests, %0d with errors, %0d mismatches",
                 tests_run, tests_failed, error_count);
        done = 1'b1;
    end

endmodule

`default_nettype wire

/* tb/tb_forward_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fwd_defines.svh"

module tb_forward_top;

    import fwd_pkg::*;

    typedef struct packed {
        logic [7:0]  test;
        logic [6:0]  opcode;
        logic [4:0]  rd;
        logic        reg_write;
        logic [2:0]  funct3;
        logic        csr_write;
        logic [11:0] csr_addr;
        logic        ex_valid;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] src_csr;
        logic [1:0]  addr_low;   // low load address bits
    } row_t;

    logic             clk;
    logic             reset;
    logic             ex_valid;
    ex_result_t       ex_result;
    logic [`XLEN-1:0] mem_read_data;
    src_req_t         src;
    logic [`XLEN-1:0] alu_forward_data_a;
    logic [`XLEN-1:0] alu_forward_data_b;
    fwd_sel_t         alu_forward_select_a;
    fwd_sel_t         alu_forward_select_b;
    logic [`XLEN-1:0] csr_forward_data;
    logic             active;
    logic             finish_req;
    logic [7:0]       test_id;
    logic             done;
    int               error_count;
    row_t             rows[$];
    logic [31:0]      rng;
    logic [31:0]      prev_word;   // memory word of the row now in MEM

    forward_top i_forward_top (
        .clk                  (clk),
        .reset                (reset),
        .ex_valid             (ex_valid),
        .ex_result            (ex_result),
        .mem_read_data        (mem_read_data),
        .src                  (src),
        .alu_forward_data_a   (alu_forward_data_a),
        .alu_forward_data_b   (alu_forward_data_b),
        .alu_forward_select_a (alu_forward_select_a),
        .alu_forward_select_b (alu_forward_select_b),
        .csr_forward_data     (csr_forward_data)
    );

    forward_checker i_forward_checker (
        .clk                  (clk),
        .reset                (reset),
        .active               (active),
        .finish_req           (finish_req),
        .test_id              (test_id),
        .ex_valid             (ex_valid),
        .ex_result            (ex_result),
        .mem_read_data        (mem_read_data),
        .src                  (src),
        .alu_forward_data_a   (alu_forward_data_a),
        .alu_forward_data_b   (alu_forward_data_b),
        .alu_forward_select_a (alu_forward_select_a),
        .alu_forward_select_b (alu_forward_select_b),
        .csr_forward_data     (csr_forward_data),
        .done                 (done),
        .error_count          (error_count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic add_row(input logic [7:0] test, input logic [6:0] opcode,
                           input logic [4:0] rd, input logic reg_write,
                           input logic [2:0] funct3, input logic csr_write,
                           input logic [11:0] csr_addr, input logic valid,
                           input logic [4:0] rs1, input logic [4:0] rs2,
                           input logic [11:0] src_csr, input logic [1:0] addr_low);
        row_t r;
        r = '{test, opcode, rd, reg_write, funct3, csr_write, csr_addr, valid,
              rs1, rs2, src_csr, addr_low};
        rows.push_back(r);
    endtask

    task automatic build_table();
        logic [6:0] ops [0:5];
        logic [2:0] sizes [0:4];
        ops[0] = `OPCODE_LOAD;
        ops[1] = `OPCODE_ENVIRONMENT;
        ops[2] = `OPCODE_LUI;
        ops[3] = `OPCODE_JAL;
        ops[4] = `OPCODE_JALR;
        ops[5] = `OPCODE_OP;
        sizes[0] = `FUNCT3_LB;
        sizes[1] = `FUNCT3_LH;
        sizes[2] = `FUNCT3_LW;
        sizes[3] = `FUNCT3_LBU;
        sizes[4] = `FUNCT3_LHU;
        // idle pipe, then producers nobody reads
        add_row(1, `OPCODE_OP, 3, 1, 0, 0, 12'h300, 0, 1, 2, 12'h300, 0);
        add_row(1, `OPCODE_OP, 7, 1, 0, 0, 12'h300, 1, 1, 2, 12'h300, 0);
        add_row(1, `OPCODE_OP_IMM, 8, 1, 0, 0, 12'h300, 1, 1, 2, 12'h301, 0);
        // same rd in both stages
        add_row(2, `OPCODE_OP, 5, 1, 0, 0, 12'h0, 1, 0, 0, 12'h0, 0);
        add_row(2, `OPCODE_OP, 5, 1, 0, 0, 12'h0, 1, 5, 6, 12'h0, 0);
        add_row(2, `OPCODE_OP, 6, 1, 0, 0, 12'h0, 0, 5, 5, 12'h0, 0);
        add_row(2, `OPCODE_OP, 6, 1, 0, 0, 12'h0, 0, 5, 5, 12'h0, 0);
        // opcode rule, read from MEM then from WB
        for (int k = 0; k < 6; k++) begin
            add_row(3, ops[k], 10, 1, `FUNCT3_LW, 0, 12'h0, 1, 0, 0, 12'h0, 0);
            add_row(3, `OPCODE_OP, 11, 1, 0, 0, 12'h0, 0, 10, 1, 12'h0, 0);
            add_row(3, `OPCODE_OP, 11, 1, 0, 0, 12'h0, 0, 1, 10, 12'h0, 0);
        end
        // x0, write disabled, bubble
        add_row(4, `OPCODE_OP, 0, 1, 0, 0, 12'h0, 1, 0, 0, 12'h0, 0);
        add_row(4, `OPCODE_OP, 9, 0, 0, 0, 12'h0, 1, 0, 0, 12'h0, 0);
        add_row(4, `OPCODE_OP, 9, 1, 0, 0, 12'h0, 0, 9, 9, 12'h0, 0);
        add_row(4, `OPCODE_OP, 4, 1, 0, 0, 12'h0, 0, 9, 9, 12'h0, 0);
        add_row(4, `OPCODE_OP, 4, 1, 0, 0, 12'h0, 0, 9, 9, 12'h0, 0);
        // rs1 reads the load in MEM, rs2 the one in WB
        for (int i = 0; i < 20; i++) begin
            add_row(5, `OPCODE_LOAD, 5'(12 + (i & 1)), 1, sizes[i / 4], 0, 12'h0, 1,
                    5'(12 + ((i + 1) & 1)), 5'(12 + (i & 1)), 12'h0, 2'(i % 4));
        end
        add_row(5, `OPCODE_OP, 1, 0, 0, 0, 12'h0, 0, 12, 13, 12'h0, 0);
        // CSR writes, priority and address match
        add_row(6, `OPCODE_ENVIRONMENT, 0, 0, 0, 1, 12'h305, 1, 0, 0, 12'h305, 0);
        add_row(6, `OPCODE_ENVIRONMENT, 0, 0, 0, 1, 12'h305, 1, 0, 0, 12'h305, 0);
        add_row(6, `OPCODE_OP, 0, 0, 0, 0, 12'h0, 0, 0, 0, 12'h305, 0);
        add_row(6, `OPCODE_ENVIRONMENT, 0, 0, 0, 1, 12'h306, 1, 0, 0, 12'h305, 0);
        add_row(6, `OPCODE_ENVIRONMENT, 0, 0, 0, 0, 12'h305, 1, 0, 0, 12'h305, 0);
        add_row(6, `OPCODE_OP, 0, 0, 0, 0, 12'h0, 0, 0, 0, 12'h305, 0);
        add_row(6, `OPCODE_OP, 0, 0, 0, 0, 12'h0, 0, 0, 0, 12'h306, 0);
    endtask

    task automatic drive_row(input row_t r);
        test_id                  = r.test;
        ex_valid                 = r.ex_valid;
        ex_result.opcode         = r.opcode;
        ex_result.rd             = r.rd;
        ex_result.reg_write      = r.reg_write;
        ex_result.funct3         = r.funct3;
        ex_result.csr_write      = r.csr_write;
        ex_result.csr_addr       = r.csr_addr;
        rng = xorshift32(rng);
        ex_result.imm            = rng;
        rng = xorshift32(rng);
        ex_result.alu_result     = {rng[31:2], r.addr_low};
        rng = xorshift32(rng);
        ex_result.csr_read_data  = rng;
        rng = xorshift32(rng);
        ex_result.pc_plus_4      = rng;
        rng = xorshift32(rng);
        ex_result.csr_write_data = rng;
        src.rs1                  = r.rs1;
        src.rs2                  = r.rs2;
        src.csr_addr             = r.src_csr;
        rng = xorshift32(rng);
        src.csr_read_data        = rng;
        mem_read_data            = prev_word;   // belongs to the row in MEM
        rng = xorshift32(rng);
        prev_word                = rng;
    endtask

    initial begin
        int wait_cycles;
        reset         = 1'b1;
        ex_valid      = 1'b0;
        ex_result     = '0;
        mem_read_data = '0;
        src           = '0;
        active        = 1'b0;
        finish_req    = 1'b0;
        test_id       = 8'd0;
        rng           = 32'd45012;
        prev_word     = 32'd0;
        build_table();
        repeat (16) @(posedge clk);
        #10 reset = 1'b0;
        foreach (rows[i]) begin
            @(posedge clk);
            #10;
            active = 1'b1;
            drive_row(rows[i]);
        end
        @(posedge clk);
        #10;
        active     = 1'b0;
        finish_req = 1'b1;
        wait_cycles = 0;
        while (!done && wait_cycles < 100) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (!done) begin
            $display("timeout: the checker did not report its counts within 100 cycles");
        end
        if (done && error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+logic
logic/fwd_pkg.sv
logic/stage_reg.sv
logic/load_align.sv
logic/hazard_detect.sv
logic/forward_unit.sv
logic/forward_top.sv
tb/forward_checker.sv
tb/tb_forward_top.sv

/* Makefile */
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        ?= tb_forward_top
FILELIST   ?= compile.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  := *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

# lint the whole tree with the testbench as top
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the log holds the pass line
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -qF '$(PASS_TEXT)' $(LOG); then \
		echo "simulation ok"; \
	else \
		echo "simulation failed, exit status $$status"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
